// File: hw/draw_pkg.sv
/*
 * Coordinate types and the 32-bit host word shared by the drawing blocks.
 * The host word is read as a point or as a control command, by address.
 */
package draw_pkg;

    localparam int coord_w = 16;                // signed screen coordinate width

    typedef logic signed [coord_w-1:0] coord_t;

    // one segment endpoint, x in the upper half of the host word
    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        logic [21:0] reserved;
        logic [3:0]  colour;                    // same width as the colour index
        logic [4:0]  line_count;                // 1 to max_lines, clamped on write
        logic        go;
    } ctrl_t;

    typedef union packed {
        point_t pt;                             // addresses 0 to 31
        ctrl_t  ctrl;                           // address ctrl_addr
    } host_word_u;

    // point k start at 2k, end at 2k+1
    localparam logic [5:0] ctrl_addr = 6'd32;

endpackage

// File: hw/fb_pkg.sv
/*
 * Colour index type and the pixel write record seen by the framebuffer.
 */
package fb_pkg;

    localparam int cidx_w = 4;                  // 16 colour palette

    typedef logic [cidx_w-1:0] cidx_t;

    // one pixel write as it arrives at the framebuffer
    typedef struct packed {
        logic             we;
        draw_pkg::coord_t x;
        draw_pkg::coord_t y;
        cidx_t            cidx;
    } pix_wr_t;

endpackage

// File: hw/shape_regs.sv
/*
 * Host register block: segment table, line count and colour, plus the go strobe.
 * Host writes are dropped while a drawing run is pending or active.
 */
`timescale 1ns/1ps

module shape_regs #(
    parameter int max_lines = 16
) (
    input  logic                               clk_100m,
    input  logic                               reset,
    input  logic                               cfg_we,
    input  logic [5:0]                         cfg_addr,
    input  draw_pkg::host_word_u               cfg_wdata,
    input  logic                               busy,
    input  logic [$clog2(max_lines)-1:0]       tbl_index,
    output draw_pkg::coord_t                   start_x,
    output draw_pkg::coord_t                   start_y,
    output draw_pkg::coord_t                   end_x,
    output draw_pkg::coord_t                   end_y,
    output logic [$clog2(max_lines+1)-1:0]     line_count,
    output fb_pkg::cidx_t                      colour,
    output logic                               go_pulse
);
    import draw_pkg::*;

    localparam int idx_w = $clog2(max_lines);
    localparam int lc_w  = $clog2(max_lines + 1);

    point_t start_tbl [max_lines];
    point_t end_tbl   [max_lines];

    logic             host_lock;
    logic             wr_ok;
    logic             is_ctrl;
    logic             is_point;
    logic [idx_w-1:0] wr_index;
    logic [4:0]       lc_req;
    logic [lc_w-1:0]  lc_clamped;

    // a go already issued counts as busy until the sequencer picks it up
    assign host_lock = busy | go_pulse;
    assign wr_ok     = cfg_we & ~host_lock;
    assign is_ctrl   = (cfg_addr == ctrl_addr);
    assign is_point  = (int'(cfg_addr) < 2 * max_lines);
    assign wr_index  = cfg_addr[idx_w:1];         // line number of the point

    assign lc_req = cfg_wdata.ctrl.line_count;

    always_comb begin
        if (lc_req == '0) begin
            lc_clamped = lc_w'(1);
        end else if (int'(lc_req) > max_lines) begin
            lc_clamped = lc_w'(max_lines);
        end else begin
            lc_clamped = lc_w'(lc_req);
        end
    end

    // control registers
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            line_count <= lc_w'(1);
            colour     <= '0;
            go_pulse   <= 1'b0;
        end else begin
            go_pulse <= 1'b0;                     // single cycle strobe
            if (wr_ok && is_ctrl) begin
                line_count <= lc_clamped;
                colour     <= cfg_wdata.ctrl.colour;
                go_pulse   <= cfg_wdata.ctrl.go;
            end
        end
    end

    // point table
    always_ff @(posedge clk_100m) begin
        if (wr_ok && is_point) begin
            if (cfg_addr[0]) begin
                end_tbl[wr_index] <= cfg_wdata.pt;
            end else begin
                start_tbl[wr_index] <= cfg_wdata.pt;
            end
        end
    end

    // combinational table read for the sequencer
    assign start_x = start_tbl[tbl_index].x;
    assign start_y = start_tbl[tbl_index].y;
    assign end_x   = end_tbl[tbl_index].x;
    assign end_y   = end_tbl[tbl_index].y;

    // a new run may only start from an idle sequencer
    go_while_busy_a: assert property (
        @(posedge clk_100m) disable iff (reset) !(go_pulse && busy)
    );

endmodule

// File: hw/shape_sequencer.sv
/*
 * Walks the segment table and starts one rasterizer run per line.
 * busy spans the first ras_start to the last ras_done; done marks the end.
 */
`timescale 1ns/1ps

module shape_sequencer #(
    parameter int max_lines = 16
) (
    input  logic                               clk_100m,
    input  logic                               reset,
    input  logic                               go_pulse,
    input  logic [$clog2(max_lines+1)-1:0]     line_count,
    input  draw_pkg::coord_t                   start_x,
    input  draw_pkg::coord_t                   start_y,
    input  draw_pkg::coord_t                   end_x,
    input  draw_pkg::coord_t                   end_y,
    input  logic                               ras_done,
    output logic [$clog2(max_lines)-1:0]       tbl_index,
    output logic                               ras_start,
    output draw_pkg::coord_t                   x0,
    output draw_pkg::coord_t                   y0,
    output draw_pkg::coord_t                   x1,
    output draw_pkg::coord_t                   y1,
    output logic                               busy,
    output logic                               done
);
    localparam int lc_w = $clog2(max_lines + 1);

    typedef enum logic [1:0] {
        idle,
        load,
        draw,
        finish
    } seq_state_t;

    seq_state_t      state;
    logic [lc_w-1:0] line_num;                    // lines started so far
    logic            last_line;

    assign last_line = (line_num == line_count);

    // tbl_index always points at the next segment to fetch
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            state     <= idle;
            tbl_index <= '0;
            line_num  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (go_pulse) begin
                        state     <= load;
                        tbl_index <= tbl_index + 1'b1;
                        line_num  <= lc_w'(1);
                    end
                end
                load: begin
                    state <= draw;                // ras_start goes out now
                end
                draw: begin
                    if (ras_done) begin
                        if (last_line) begin
                            state <= finish;
                        end else begin
                            state     <= load;
                            tbl_index <= tbl_index + 1'b1;
                            line_num  <= line_num + 1'b1;
                        end
                    end
                end
                default: begin                    // finish
                    state     <= idle;
                    tbl_index <= '0;
                end
            endcase
        end
    end

    // segment endpoints, held for the whole run
    always_ff @(posedge clk_100m) begin
        if ((state == idle && go_pulse) || (state == draw && ras_done && !last_line)) begin
            x0 <= start_x;
            y0 <= start_y;
            x1 <= end_x;
            y1 <= end_y;
        end
    end

    assign ras_start = (state == load);
    assign busy      = (state == load) || (state == draw);
    assign done      = (state == finish);

    // the rasterizer only finishes a run that was started from here
    done_in_draw_a: assert property (
        @(posedge clk_100m) disable iff (reset) ras_done |-> state == draw
    );

endmodule

// File: hw/line_rasterizer.sv
/*
 * Integer Bresenham line engine, one pixel per cycle in any octant.
 * One setup cycle after ras_start, then max(|dx|,|dy|)+1 pixels and ras_done.
 */
`timescale 1ns/1ps

module line_rasterizer (
    input  logic             clk_100m,
    input  logic             reset,
    input  logic             ras_start,
    input  draw_pkg::coord_t x0,
    input  draw_pkg::coord_t y0,
    input  draw_pkg::coord_t x1,
    input  draw_pkg::coord_t y1,
    output logic             pix_we,
    output draw_pkg::coord_t pix_x,
    output draw_pkg::coord_t pix_y,
    output logic             ras_done
);
    import draw_pkg::*;

    localparam int dw = coord_w + 2;              // room for 2*err without overflow

    typedef enum logic [1:0] {
        idle,
        setup,
        run,
        fin
    } ras_state_t;

    ras_state_t state;

    logic signed [dw-1:0] dx_raw;
    logic signed [dw-1:0] dy_raw;
    logic signed [dw-1:0] dx;                     // |x1-x0|
    logic signed [dw-1:0] dy;                     // -|y1-y0|
    logic signed [dw-1:0] err;
    logic signed [dw:0]   e2;
    logic                 sx_neg;
    logic                 sy_neg;
    logic                 step_x;
    logic                 step_y;
    logic                 at_end;
    coord_t               x_cur;
    coord_t               y_cur;

    assign dx_raw = x1 - x0;
    assign dy_raw = y1 - y0;

    assign e2     = {err, 1'b0};
    assign step_x = (e2 >= dy);
    assign step_y = (e2 <= dx);
    assign at_end = (x_cur == x1) && (y_cur == y1);

    // control
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (ras_start) begin
                        state <= setup;
                    end
                end
                setup: state <= run;
                run: begin
                    if (at_end) begin
                        state <= fin;
                    end
                end
                default: state <= idle;           // fin
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_100m) begin
        case (state)
            idle: begin
                if (ras_start) begin
                    dx     <= (dx_raw < 0) ? -dx_raw : dx_raw;
                    dy     <= (dy_raw < 0) ? dy_raw : -dy_raw;
                    sx_neg <= (dx_raw < 0);
                    sy_neg <= (dy_raw < 0);
                    x_cur  <= x0;
                    y_cur  <= y0;
                end
            end
            setup: begin
                err <= dx + dy;
            end
            run: begin
                if (!at_end) begin
                    if (step_x && step_y) begin
                        err <= err + dx + dy;     // diagonal step
                    end else if (step_x) begin
                        err <= err + dy;
                    end else if (step_y) begin
                        err <= err + dx;
                    end
                    if (step_x) begin
                        x_cur <= sx_neg ? x_cur - 1'b1 : x_cur + 1'b1;
                    end
                    if (step_y) begin
                        y_cur <= sy_neg ? y_cur - 1'b1 : y_cur + 1'b1;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    assign pix_we   = (state == run);
    assign pix_x    = x_cur;
    assign pix_y    = y_cur;
    assign ras_done = (state == fin);

    // the sequencer waits for ras_done before the next segment
    start_when_idle_a: assert property (
        @(posedge clk_100m) disable iff (reset) ras_start |-> state == idle
    );

endmodule

// File: hw/framebuffer.sv
/*
 * Pixel memory of colour indices with a clipped write port and a registered read.
 * Contents start at zero; reads outside the screen return 0.
 */
`timescale 1ns/1ps

module framebuffer #(
    parameter int fb_width  = 64,
    parameter int fb_height = 48
) (
    input  logic             clk_100m,
    input  logic             pix_we,
    input  draw_pkg::coord_t pix_x,
    input  draw_pkg::coord_t pix_y,
    input  fb_pkg::cidx_t    colour,
    input  draw_pkg::coord_t rd_x,
    input  draw_pkg::coord_t rd_y,
    output fb_pkg::cidx_t    rd_cidx
);
    import fb_pkg::*;

    localparam int depth = fb_width * fb_height;
    localparam int aw    = $clog2(depth);

    cidx_t mem [depth];

    pix_wr_t       wr;
    logic          wr_ok;
    logic          rd_in;
    logic [aw-1:0] wr_addr;
    logic [aw-1:0] rd_addr;

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;                          // blank screen
        end
    end

    assign wr = '{we: pix_we, x: pix_x, y: pix_y, cidx: colour};

    // clip so off-screen pixels never wrap onto another row
    assign wr_ok = wr.we
                 && (wr.x >= 0) && (wr.x < fb_width)
                 && (wr.y >= 0) && (wr.y < fb_height);
    assign rd_in = (rd_x >= 0) && (rd_x < fb_width)
                 && (rd_y >= 0) && (rd_y < fb_height);

    assign wr_addr = aw'(wr.y) * aw'(fb_width) + aw'(wr.x);
    assign rd_addr = aw'(rd_y) * aw'(fb_width) + aw'(rd_x);

    always_ff @(posedge clk_100m) begin
        if (wr_ok) begin
            mem[wr_addr] <= wr.cidx;
        end
    end

    always_ff @(posedge clk_100m) begin
        rd_cidx <= rd_in ? mem[rd_addr] : '0;     // one cycle read
    end

    // rasterizer coordinates after clipping must land inside the memory
    wr_in_range_a: assert property (
        @(posedge clk_100m) wr_ok |-> int'(wr_addr) < depth
    );

endmodule

// File: hw/shape_draw_top.sv
/*
 * Line drawing subsystem: host registers, sequencer, Bresenham rasterizer
 * and framebuffer, on one clock. Screen size and table depth are set here.
 */
`timescale 1ns/1ps

module shape_draw_top #(
    parameter int fb_width  = 64,
    parameter int fb_height = 48,
    parameter int max_lines = 16
) (
    input  logic                 clk_100m,
    input  logic                 reset,
    input  logic                 cfg_we,
    input  logic [5:0]           cfg_addr,
    input  draw_pkg::host_word_u cfg_wdata,
    input  draw_pkg::coord_t     rd_x,
    input  draw_pkg::coord_t     rd_y,
    output logic                 busy,
    output logic                 done,
    output fb_pkg::cidx_t        rd_cidx
);
    import draw_pkg::*;
    import fb_pkg::*;

    localparam int idx_w = $clog2(max_lines);
    localparam int lc_w  = $clog2(max_lines + 1);

    logic [idx_w-1:0] tbl_index;
    logic [lc_w-1:0]  line_count;
    cidx_t            colour;
    logic             go_pulse;
    coord_t           start_x, start_y, end_x, end_y;   // table read
    coord_t           x0, y0, x1, y1;                   // current segment
    logic             ras_start, ras_done;
    logic             pix_we;
    coord_t           pix_x, pix_y;

    shape_regs #(
        .max_lines(max_lines)
    ) shape_regs_inst (
        .clk_100m,
        .reset,
        .cfg_we,
        .cfg_addr,
        .cfg_wdata,
        .busy,
        .tbl_index,
        .start_x,
        .start_y,
        .end_x,
        .end_y,
        .line_count,
        .colour,
        .go_pulse
    );

    shape_sequencer #(
        .max_lines(max_lines)
    ) shape_sequencer_inst (
        .clk_100m,
        .reset,
        .go_pulse,
        .line_count,
        .start_x,
        .start_y,
        .end_x,
        .end_y,
        .ras_done,
        .tbl_index,
        .ras_start,
        .x0,
        .y0,
        .x1,
        .y1,
        .busy,
        .done
    );

    line_rasterizer line_rasterizer_inst (
        .clk_100m,
        .reset,
        .ras_start,
        .x0,
        .y0,
        .x1,
        .y1,
        .pix_we,
        .pix_x,
        .pix_y,
        .ras_done
    );

    framebuffer #(
        .fb_width(fb_width),
        .fb_height(fb_height)
    ) framebuffer_inst (
        .clk_100m,
        .pix_we,
        .pix_x,
        .pix_y,
        .colour,                                  // stable while busy
        .rd_x,
        .rd_y,
        .rd_cidx
    );

endmodule

// File: verif/tb_shape_draw.sv
/*
 * Testbench for the line drawing subsystem. Random shapes are checked against a
 * Bresenham model, with a full framebuffer readback after every done.
 */
`timescale 1ns/1ps

module tb_shape_draw;
    import draw_pkg::*;
    import fb_pkg::*;

    localparam int fb_width   = 64;
    localparam int fb_height  = 48;
    localparam int max_lines  = 16;
    localparam int num_shapes = 32;
    localparam int done_limit = max_lines * 70 + 100;     // cycles from go to done
    localparam longint wd_cycles = num_shapes * (max_lines * 70 + 3100) + 5000;

    logic       clk_100m = 1'b0;
    logic       reset;
    logic       cfg_we;
    logic [5:0] cfg_addr;
    host_word_u cfg_wdata;
    coord_t     rd_x;
    coord_t     rd_y;
    logic       busy;
    logic       done;
    cidx_t      rd_cidx;

    int    seed = 32'h165f021f;
    int    pixel_errors = 0;
    int    other_errors = 0;
    int    done_seen = 0;
    int    shapes_drawn = 0;
    int    model_lc;
    cidx_t model_colour;
    int    tbl_sx [max_lines];                            // model copy of the segment table
    int    tbl_sy [max_lines];
    int    tbl_ex [max_lines];
    int    tbl_ey [max_lines];
    cidx_t model_fb [fb_height][fb_width];

    always #5 clk_100m = ~clk_100m;

    shape_draw_top #(
        .fb_width(fb_width),
        .fb_height(fb_height),
        .max_lines(max_lines)
    ) shape_draw_top_inst (
        .clk_100m,
        .reset,
        .cfg_we,
        .cfg_addr,
        .cfg_wdata,
        .rd_x,
        .rd_y,
        .busy,
        .done,
        .rd_cidx
    );

    always @(posedge clk_100m) begin
        if (!reset && done) begin
            done_seen <= done_seen + 1;
        end
    end

    initial begin
        #(wd_cycles * 10);
        $display("watchdog expired after %0d cycles, run stopped", wd_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    function automatic int clamp_count(input int req);
        if (req == 0) begin
            return 1;
        end else if (req > max_lines) begin
            return max_lines;
        end
        return req;
    endfunction

    task automatic plot(input int x, input int y, input cidx_t c);
        if (x >= 0 && x < fb_width && y >= 0 && y < fb_height) begin
            model_fb[y][x] = c;                           // last write wins
        end
    endtask

    // reference Bresenham, endpoints included, all octants
    task automatic model_line(input int ax, input int ay, input int bx, input int by,
                              input cidx_t c);
        int dx;
        int dy;
        int sx;
        int sy;
        int err;
        int e2;
        int x;
        int y;
        bit at_end;
        dx = (bx > ax) ? bx - ax : ax - bx;
        dy = (by > ay) ? ay - by : by - ay;               // negative magnitude
        sx = (ax < bx) ? 1 : -1;
        sy = (ay < by) ? 1 : -1;
        err = dx + dy;
        x = ax;
        y = ay;
        at_end = 1'b0;
        while (!at_end) begin
            plot(x, y, c);
            if (x == bx && y == by) begin
                at_end = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x += sx;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y += sy;
                end
            end
        end
    endtask

    task automatic host_write(input logic [5:0] addr, input host_word_u word);
        @(posedge clk_100m);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= word;
    endtask

    task automatic host_idle();
        @(posedge clk_100m);
        cfg_we <= 1'b0;
    endtask

    task automatic load_line(input int k, input int ax, input int ay,
                             input int bx, input int by);
        host_word_u w;
        w.pt.x = coord_t'(ax);
        w.pt.y = coord_t'(ay);
        host_write(6'(2 * k), w);
        w.pt.x = coord_t'(bx);
        w.pt.y = coord_t'(by);
        host_write(6'(2 * k + 1), w);
        tbl_sx[k] = ax;
        tbl_sy[k] = ay;
        tbl_ex[k] = bx;
        tbl_ey[k] = by;
    endtask

    task automatic load_random_line(input int k, input int lo_x, input int hi_x,
                                    input int lo_y, input int hi_y);
        int ax;
        int ay;
        int bx;
        int by;
        ax = rand_range(lo_x, hi_x);
        ay = rand_range(lo_y, hi_y);
        bx = rand_range(lo_x, hi_x);
        by = rand_range(lo_y, hi_y);
        if (rand_range(0, 7) == 0) begin
            bx = ax;                                      // single point line
            by = ay;
        end
        load_line(k, ax, ay, bx, by);
    endtask

    task automatic start_shape(input int lc_req, input cidx_t c);
        host_word_u w;
        int k;
        w = '0;
        w.ctrl.go         = 1'b1;
        w.ctrl.line_count = 5'(lc_req);
        w.ctrl.colour     = c;
        host_write(ctrl_addr, w);
        host_idle();
        model_lc     = clamp_count(lc_req);
        model_colour = c;
        for (k = 0; k < model_lc; k++) begin
            model_line(tbl_sx[k], tbl_sy[k], tbl_ex[k], tbl_ey[k], model_colour);
        end
        shapes_drawn++;
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (!busy && n < 10) begin
            @(posedge clk_100m);
            n++;
        end
        if (!busy) begin
            $display("error: busy never rose after go (shape %0d)", shapes_drawn);
            other_errors++;
        end
    endtask

    task automatic wait_done();
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < done_limit) begin
            @(posedge clk_100m);
            if (done) begin
                seen = 1'b1;
            end
            n++;
        end
        if (!seen) begin
            $display("error: no done within %0d cycles of go (shape %0d)", done_limit,
                     shapes_drawn);
            other_errors++;
        end
    endtask

    // read address n goes out, its data is back two edges later
    task automatic check_picture();
        int n;
        int px;
        int py;
        for (n = 0; n < fb_width * fb_height + 2; n++) begin
            @(posedge clk_100m);
            if (n >= 2) begin
                px = (n - 2) % fb_width;
                py = (n - 2) / fb_width;
                if (rd_cidx !== model_fb[py][px]) begin
                    $display("MISMATCH rd_cidx x=%0h y=%0h expected=%0h actual=%0h",
                             px, py, model_fb[py][px], rd_cidx);
                    pixel_errors++;
                end
            end
            if (n < fb_width * fb_height) begin
                rd_x <= coord_t'(n % fb_width);
                rd_y <= coord_t'(n / fb_width);
            end
        end
    endtask

    task automatic finish_shape();
        wait_done();
        check_picture();
        if (busy !== 1'b0) begin
            $display("MISMATCH busy expected=0 actual=%0h", busy);
            other_errors++;
        end
        if (done_seen != shapes_drawn) begin
            $display("MISMATCH done_count expected=%0h actual=%0h", shapes_drawn, done_seen);
            other_errors++;
        end
    endtask

    initial begin
        host_word_u w;
        int s;
        int k;
        int lc;
        reset     = 1'b1;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rd_x      = '0;
        rd_y      = '0;
        for (int y = 0; y < fb_height; y++) begin
            for (int x = 0; x < fb_width; x++) begin
                model_fb[y][x] = '0;
            end
        end
        repeat (5) @(posedge clk_100m);
        reset <= 1'b0;
        @(posedge clk_100m);
        if (busy !== 1'b0) begin
            $display("MISMATCH busy expected=0 actual=%0h", busy);
            other_errors++;
        end
        if (done !== 1'b0) begin
            $display("MISMATCH done expected=0 actual=%0h", done);
            other_errors++;
        end

        // horizontal then vertical, colour 5
        load_line(0, 5, 10, 50, 10);
        start_shape(1, 4'd5);
        finish_shape();
        load_line(0, 30, 2, 30, 40);
        start_shape(1, 4'd5);
        finish_shape();

        // random shapes inside the screen
        for (s = 0; s < 20; s++) begin
            lc = rand_range(1, max_lines);
            for (k = 0; k < lc; k++) begin
                load_random_line(k, 0, fb_width - 1, 0, fb_height - 1);
            end
            start_shape(lc, cidx_t'(rand_range(1, 15)));
            finish_shape();
        end

        // clipping at all edges
        load_line(0, 50, 20, 90, 20);                     // would wrap onto row 21
        load_line(1, -10, -5, 20, 25);
        load_line(2, 70, -30, -20, 60);
        load_line(3, -50, 48, 120, 48);                   // just below the screen
        start_shape(4, 4'd9);
        finish_shape();
        for (s = 0; s < 2; s++) begin
            for (k = 0; k < 4; k++) begin
                load_random_line(k, -60, 120, -60, 100);
            end
            start_shape(4, cidx_t'(rand_range(1, 15)));
            finish_shape();
        end

        // overlapping shapes, later colour wins
        load_line(0, 0, 24, 63, 24);
        load_line(1, 0, 0, 47, 47);
        start_shape(2, 4'd2);
        finish_shape();
        load_line(0, 32, 0, 32, 47);
        load_line(1, 63, 0, 16, 47);
        start_shape(2, 4'd7);
        finish_shape();
        for (k = 0; k < 3; k++) begin
            load_random_line(k, 0, fb_width - 1, 0, fb_height - 1);
        end
        start_shape(3, 4'd11);
        finish_shape();

        // host writes while busy are dropped
        for (k = 0; k < 4; k++) begin
            load_line(k, 0, 4 * k + 5, 63, 4 * k + 5);
        end
        start_shape(4, 4'd3);
        wait_busy();
        w = '0;
        w.ctrl.go         = 1'b1;
        w.ctrl.line_count = 5'd2;
        w.ctrl.colour     = 4'd9;
        host_write(ctrl_addr, w);
        for (k = 0; k < 4; k++) begin
            w.pt.x = coord_t'(k + 1);
            w.pt.y = coord_t'(40 - k);
            host_write(6'(k), w);
        end
        host_idle();
        finish_shape();
        start_shape(4, 4'd12);                            // table as before the drops
        finish_shape();

        // line_count clamping
        for (k = 0; k < max_lines; k++) begin
            load_random_line(k, 0, fb_width - 1, 0, fb_height - 1);
        end
        start_shape(0, 4'd6);
        finish_shape();
        start_shape(25, 4'd13);
        finish_shape();

        $display("pixel errors: %0d, other errors: %0d", pixel_errors, other_errors);
        if (pixel_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
hw/draw_pkg.sv
hw/fb_pkg.sv
hw/shape_regs.sv
hw/shape_sequencer.sv
hw/line_rasterizer.sv
hw/framebuffer.sv
hw/shape_draw_top.sv
verif/tb_shape_draw.sv

// File: Makefile
# Verilator build and run of the line drawing testbench

TOP := tb_shape_draw
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sim.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
